/* filelist.f */
+incdir+common
common/periph_bus_pkg.sv
common/periph_irq_pkg.sv
source/apb_decoder.sv
plic/irq_ctrl.sv
timer/timer_regs.sv
timer/timer_counter.sv
source/periph_subsys_top.sv
testbench/tb_periph_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module tb_periph_subsys \
  -f filelist.f \
  -o sim_periph_subsys
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_periph_subsys)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

/* testbench/tb_periph_subsys.sv */
// Self-checking testbench of the peripheral subsystem. Drives the APB port
// and the external interrupt lines, keeps a model of the interrupt registers
// and checks readback, error responses, arbitration and the timer interrupt.

`timescale 1ns/1ps

`include "periph_macros.svh"

module tb_periph_subsys
  import periph_bus_pkg::*;
  import periph_irq_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 200;
  localparam int IRQ_OFF_CLAIM  = 'h18;

  logic                    clk;
  logic                    reset;
  apb_req_t                apb_req;
  apb_resp_t               apb_resp;
  logic [`NUM_IRQ_SRC-2:0] ext_irq;
  logic                    irq;

  // Register model of the interrupt controller
  irq_prio_t model_prio [`NUM_IRQ_SRC];
  irq_src_t  model_en;
  irq_prio_t model_thr;
  irq_src_t  model_pend;

  periph_data_t            last_rdata;
  logic                    last_err;
  periph_data_t            rd;
  periph_data_t            val;
  irq_id_t                 id;
  logic [`NUM_IRQ_SRC-2:0] lines;
  int                      err_count;
  int                      cycles;
  int                      test_errs;
  int                      total_errs;
  int                      tests_passed;
  int                      tests_failed;

  periph_subsys_top dut (
    .clk_i      ( clk      ),
    .reset_i    ( reset    ),
    .apb_req_i  ( apb_req  ),
    .apb_resp_o ( apb_resp ),
    .ext_irq_i  ( ext_irq  ),
    .irq_o      ( irq      )
  );

  always #5 clk = ~clk;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic periph_addr_t slot_addr(input int slot, input int offset);
    return (periph_addr_t'(slot) << `PERIPH_SLOT_LSB) | periph_addr_t'(offset);
  endfunction

  // Highest priority first, lowest id first within one priority
  function automatic irq_id_t best_id();
    for (int p = (1 << `IRQ_PRIO_W) - 1; p > 0; p--) begin
      for (int i = 0; i < `NUM_IRQ_SRC; i++) begin
        if (model_pend[i] && model_en[i] && (model_prio[i] == irq_prio_t'(p))) begin
          return irq_id_t'(i + 1);
        end
      end
    end
    return '0;
  endfunction

  function automatic logic irq_expected();
    irq_id_t best;
    best = best_id();
    if (best == '0) begin
      return 1'b0;
    end
    return model_prio[int'(best) - 1] > model_thr;
  endfunction

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
    end
  endtask

  task automatic check(input string name, input periph_data_t got, input periph_data_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic apb_transfer(input logic wr, input periph_addr_t addr,
                              input periph_data_t wdata);
    int wait_cnt;
    @(posedge clk);
    apb_req.paddr   <= addr; // Setup phase
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.pwdata  <= wdata;
    apb_req.pstrb   <= 4'hF;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    wait_cnt = 0;
    @(negedge clk);
    while (!apb_resp.pready && (wait_cnt < TIMEOUT_CYCLES)) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!apb_resp.pready) begin
      $display("timeout waiting for pready at address 0x%08h", addr);
      test_errs++;
    end
    last_rdata = apb_resp.prdata;
    last_err   = apb_resp.pslverr;
    @(posedge clk); // Edge that ends the access phase
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_write(input periph_addr_t addr, input periph_data_t wdata);
    apb_transfer(1'b1, addr, wdata);
  endtask

  task automatic apb_read(input periph_addr_t addr, output periph_data_t rdata);
    apb_transfer(1'b0, addr, '0);
    rdata = last_rdata;
  endtask

  task automatic write_readback(input string name, input periph_addr_t addr,
                                input periph_data_t mask, output periph_data_t value);
    periph_data_t wdata;
    periph_data_t got;
    wdata = $urandom;
    value = wdata & mask;
    apb_write(addr, wdata);
    apb_read(addr, got);
    check(name, got, value);
    check("pslverr", periph_data_t'(last_err), 32'h0);
  endtask

  task automatic claim_and_check(output irq_id_t exp);
    periph_data_t got;
    exp = best_id();
    apb_read(slot_addr(`IRQ_CTRL_SLOT, IRQ_OFF_CLAIM), got);
    check("claim id", got, periph_data_t'(exp));
    if (exp != '0) begin
      model_pend[int'(exp) - 1] = 1'b0;
    end
  endtask

  // Enables every source and claims and completes until nothing is left
  task automatic drain_pending();
    irq_id_t got_id;
    for (int i = 0; i < `NUM_IRQ_SRC; i++) begin
      model_prio[i] = irq_prio_t'(1);
      apb_write(slot_addr(`IRQ_CTRL_SLOT, 4 * i), 32'h1);
    end
    model_en  = '1;
    model_thr = '0;
    apb_write(slot_addr(`IRQ_CTRL_SLOT, 'h10), periph_data_t'(model_en));
    apb_write(slot_addr(`IRQ_CTRL_SLOT, 'h14), 32'h0);
    for (int n = 0; n <= `NUM_IRQ_SRC; n++) begin
      claim_and_check(got_id);
      if (got_id == '0) begin
        break;
      end
      apb_write(slot_addr(`IRQ_CTRL_SLOT, IRQ_OFF_CLAIM), periph_data_t'(got_id));
    end
  endtask

  task automatic end_test(input int num, input string name);
    if (test_errs == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("test %0d %s: %0s (%0d errors)", num, name,
             (test_errs == 0) ? "ok" : "FAILED", test_errs);
    total_errs += test_errs;
    test_errs   = 0;
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(32'h2d52));
    clk          = 1'b0;
    reset        = 1'b1;
    apb_req      = '0;
    ext_irq      = '0;
    model_en     = '0;
    model_thr    = '0;
    model_pend   = '0;
    test_errs    = 0;
    total_errs   = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int i = 0; i < `NUM_IRQ_SRC; i++) begin
      model_prio[i] = '0;
    end
    wait_cycles(8);
    reset <= 1'b0;

    // Register readback
    @(negedge clk);
    check("irq_o", periph_data_t'(irq), 32'h0);
    for (int i = 0; i < `NUM_IRQ_SRC; i++) begin
      write_readback("prdata priority", slot_addr(`IRQ_CTRL_SLOT, 4 * i),
                     (1 << `IRQ_PRIO_W) - 1, val);
      model_prio[i] = irq_prio_t'(val);
    end
    write_readback("prdata enable", slot_addr(`IRQ_CTRL_SLOT, 'h10),
                   (1 << `NUM_IRQ_SRC) - 1, val);
    model_en = irq_src_t'(val);
    write_readback("prdata threshold", slot_addr(`IRQ_CTRL_SLOT, 'h14),
                   (1 << `IRQ_PRIO_W) - 1, val);
    model_thr = irq_prio_t'(val);
    write_readback("prdata prescale", slot_addr(`TIMER_SLOT, 'h04),
                   (1 << `TIMER_PRESCALE_W) - 1, val);
    write_readback("prdata compare", slot_addr(`TIMER_SLOT, 'h0C), '1, val);
    end_test(1, "register readback");

    // Unmapped slots
    err_count = 0;
    for (int s = `NUM_SLAVES; s < (1 << `PERIPH_SLOT_W); s++) begin
      if (s % 2 == 1) begin
        apb_write(slot_addr(s, $urandom_range(1023, 0) << 2), $urandom);
      end else begin
        apb_read(slot_addr(s, $urandom_range(1023, 0) << 2), rd);
      end
      check("prdata", last_rdata, 32'h0);
      check("pslverr", periph_data_t'(last_err), 32'h1);
      err_count++;
    end
    apb_read(slot_addr(`IRQ_CTRL_SLOT, 'h3C), rd);
    check("error count", rd, periph_data_t'(err_count));
    end_test(2, "unmapped slots");

    // Priority and threshold
    for (int round = 0; round < 8; round++) begin
      for (int i = 0; i < `NUM_IRQ_SRC; i++) begin
        model_prio[i] = irq_prio_t'($urandom);
        apb_write(slot_addr(`IRQ_CTRL_SLOT, 4 * i), periph_data_t'(model_prio[i]));
      end
      model_en  = irq_src_t'($urandom);
      model_thr = irq_prio_t'($urandom);
      apb_write(slot_addr(`IRQ_CTRL_SLOT, 'h10), periph_data_t'(model_en));
      apb_write(slot_addr(`IRQ_CTRL_SLOT, 'h14), periph_data_t'(model_thr));
      lines = 3'($urandom);
      @(posedge clk);
      ext_irq <= lines;
      wait_cycles(2);
      model_pend = model_pend | {lines, 1'b0};
      @(negedge clk);
      check("irq_o", periph_data_t'(irq), periph_data_t'(irq_expected()));
      apb_read(slot_addr(`IRQ_CTRL_SLOT, 'h1C), rd);
      check("pending", rd, periph_data_t'(model_pend));
      claim_and_check(id);
      @(posedge clk);
      ext_irq <= '0; // Lines drop before complete so nothing pends again
      wait_cycles(1);
      if (id != '0) begin
        apb_write(slot_addr(`IRQ_CTRL_SLOT, IRQ_OFF_CLAIM), periph_data_t'(id));
      end
    end
    end_test(3, "priority and threshold");

    // Claim and complete on id 3
    drain_pending();
    model_prio[2] = irq_prio_t'(5);
    model_en      = 4'b0100;
    apb_write(slot_addr(`IRQ_CTRL_SLOT, 'h08), 32'h5);
    apb_write(slot_addr(`IRQ_CTRL_SLOT, 'h10), periph_data_t'(model_en));
    @(posedge clk);
    ext_irq <= 3'b010;
    wait_cycles(2);
    model_pend[2] = 1'b1;
    claim_and_check(id);
    wait_cycles(4);
    apb_read(slot_addr(`IRQ_CTRL_SLOT, 'h1C), rd);
    check("pending", rd, periph_data_t'(model_pend));
    claim_and_check(id);
    @(negedge clk);
    check("irq_o", periph_data_t'(irq), 32'h0);
    apb_write(slot_addr(`IRQ_CTRL_SLOT, IRQ_OFF_CLAIM), 32'h3);
    wait_cycles(2);
    model_pend[2] = 1'b1; // Line still high
    apb_read(slot_addr(`IRQ_CTRL_SLOT, 'h1C), rd);
    check("pending", rd, periph_data_t'(model_pend));
    claim_and_check(id);
    @(posedge clk);
    ext_irq <= '0;
    wait_cycles(1);
    apb_write(slot_addr(`IRQ_CTRL_SLOT, IRQ_OFF_CLAIM), 32'h3);
    model_en = '1;
    apb_write(slot_addr(`IRQ_CTRL_SLOT, 'h10), periph_data_t'(model_en));
    apb_read(slot_addr(`IRQ_CTRL_SLOT, IRQ_OFF_CLAIM), rd);
    check("empty claim", rd, 32'h0);
    end_test(4, "claim and complete");

    // Timer interrupt on id 1
    model_prio[0] = irq_prio_t'(7);
    model_en      = 4'b0001;
    apb_write(slot_addr(`IRQ_CTRL_SLOT, 'h00), 32'h7);
    apb_write(slot_addr(`IRQ_CTRL_SLOT, 'h10), periph_data_t'(model_en));
    apb_write(slot_addr(`TIMER_SLOT, 'h08), 32'h0);
    apb_write(slot_addr(`TIMER_SLOT, 'h0C), 32'h5);
    apb_write(slot_addr(`TIMER_SLOT, 'h04), 32'h1);
    apb_write(slot_addr(`TIMER_SLOT, 'h00), 32'h1);
    cycles = 0;
    while (!irq && (cycles < TIMEOUT_CYCLES)) begin
      @(negedge clk);
      cycles++;
    end
    if (!irq) begin
      $display("timeout waiting for the timer interrupt");
      test_errs++;
    end
    model_pend[0] = 1'b1;
    claim_and_check(id);
    apb_write(slot_addr(`TIMER_SLOT, 'h00), 32'h0);
    apb_write(slot_addr(`TIMER_SLOT, 'h10), 32'h1);
    apb_write(slot_addr(`IRQ_CTRL_SLOT, IRQ_OFF_CLAIM), 32'h1);
    wait_cycles(2);
    @(negedge clk);
    check("irq_o", periph_data_t'(irq), 32'h0);
    apb_read(slot_addr(`TIMER_SLOT, 'h08), rd);
    check("count below compare", periph_data_t'(rd < 32'h5), 32'h1);
    end_test(5, "timer interrupt");

    $display("tests passed %0d, failed %0d, check errors %0d",
             tests_passed, tests_failed, total_errs);
    if ((tests_failed == 0) && (total_errs == 0)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* source/periph_subsys_top.sv */
// Peripheral subsystem top level. One APB port feeds the decoder, which
// serves the interrupt controller in slot 0 and the timer in slot 1.
// The timer and three external lines are the interrupt sources.

`timescale 1ns/1ps

`include "periph_macros.svh"

module periph_subsys_top
  import periph_bus_pkg::*;
  import periph_irq_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  apb_req_t                apb_req_i,
  output apb_resp_t               apb_resp_o,
  input  logic [`NUM_IRQ_SRC-2:0] ext_irq_i,
  output logic                    irq_o
);

  apb_req_t  [`NUM_SLAVES-1:0]  slv_req;
  apb_resp_t [`NUM_SLAVES-1:0]  slv_resp;

  irq_src_t                     irq_src;
  logic                         timer_irq;
  logic                         timer_en;
  logic [`TIMER_PRESCALE_W-1:0] timer_prescale;
  periph_data_t                 timer_compare;
  periph_data_t                 timer_count;
  logic                         timer_match;
  logic                         count_wr;
  periph_data_t                 count_wdata;

  assign irq_src = {ext_irq_i, timer_irq}; // Timer is id 1

  apb_decoder i_apb_decoder (
    .clk_i,
    .reset_i,
    .apb_req_i  ( apb_req_i  ),
    .apb_resp_o ( apb_resp_o ),
    .slv_req_o  ( slv_req    ),
    .slv_resp_i ( slv_resp   )
  );

  irq_ctrl i_irq_ctrl (
    .clk_i,
    .reset_i,
    .apb_req_i  ( slv_req[`IRQ_CTRL_SLOT]  ),
    .apb_resp_o ( slv_resp[`IRQ_CTRL_SLOT] ),
    .irq_src_i  ( irq_src                  ),
    .irq_o      ( irq_o                    )
  );

  timer_regs i_timer_regs (
    .clk_i,
    .reset_i,
    .apb_req_i     ( slv_req[`TIMER_SLOT]  ),
    .apb_resp_o    ( slv_resp[`TIMER_SLOT] ),
    .count_i       ( timer_count           ),
    .match_i       ( timer_match           ),
    .enable_o      ( timer_en              ),
    .prescale_o    ( timer_prescale        ),
    .compare_o     ( timer_compare         ),
    .count_wr_o    ( count_wr              ),
    .count_wdata_o ( count_wdata           ),
    .irq_o         ( timer_irq             )
  );

  timer_counter i_timer_counter (
    .clk_i,
    .reset_i,
    .enable_i      ( timer_en       ),
    .prescale_i    ( timer_prescale ),
    .compare_i     ( timer_compare  ),
    .count_wr_i    ( count_wr       ),
    .count_wdata_i ( count_wdata    ),
    .count_o       ( timer_count    ),
    .match_o       ( timer_match    )
  );

endmodule

/* timer/timer_counter.sv */
// Prescaled up-counter of the timer. Advances once every prescale+1 cycles
// while enabled, wraps to 0 where it would reach compare and pulses match.

`timescale 1ns/1ps

`include "periph_macros.svh"

module timer_counter
  import periph_bus_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         enable_i,
  input  logic [`TIMER_PRESCALE_W-1:0] prescale_i,
  input  periph_data_t                 compare_i,
  input  logic                         count_wr_i,
  input  periph_data_t                 count_wdata_i,
  output periph_data_t                 count_o,
  output logic                         match_o
);

  logic [`TIMER_PRESCALE_W-1:0] div_q;
  logic                         tick;
  periph_data_t                 count_next;

  assign tick       = enable_i && (div_q == prescale_i);
  assign count_next = count_o + 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      div_q   <= '0;
      count_o <= '0;
      match_o <= 1'b0;
    end else begin
      div_q   <= (enable_i && !tick) ? div_q + 1'b1 : '0; // Restarts when disabled
      match_o <= 1'b0;
      if (count_wr_i) begin
        count_o <= count_wdata_i; // Load beats counting
      end else if (tick) begin
        if (count_next == compare_i) begin
          count_o <= '0;
          match_o <= 1'b1;
        end else begin
          count_o <= count_next;
        end
      end
    end
  end

endmodule

/* timer/timer_regs.sv */
// Timer register block on APB. Holds control, prescale and compare, passes
// count writes on to the counter and keeps the match status that drives
// the timer interrupt.

`timescale 1ns/1ps

`include "periph_macros.svh"

module timer_regs
  import periph_bus_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  apb_req_t                     apb_req_i,
  output apb_resp_t                    apb_resp_o,
  input  periph_data_t                 count_i,
  input  logic                         match_i,
  output logic                         enable_o,
  output logic [`TIMER_PRESCALE_W-1:0] prescale_o,
  output periph_data_t                 compare_o,
  output logic                         count_wr_o,
  output periph_data_t                 count_wdata_o,
  output logic                         irq_o
);

  localparam logic [2:0] REG_CTRL     = 3'd0;
  localparam logic [2:0] REG_PRESCALE = 3'd1;
  localparam logic [2:0] REG_COUNT    = 3'd2;
  localparam logic [2:0] REG_COMPARE  = 3'd3;
  localparam logic [2:0] REG_STATUS   = 3'd4;

  logic       status_q;
  logic [2:0] reg_off;
  logic       acc_wr;

  assign reg_off = apb_req_i.paddr[4:2];
  assign acc_wr  = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

  // Count load strobe lasts the single access cycle
  assign count_wr_o    = acc_wr && (reg_off == REG_COUNT);
  assign count_wdata_o = apb_req_i.pwdata;
  assign irq_o         = status_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_o   <= 1'b0;
      prescale_o <= '0;
      compare_o  <= '0;
      status_q   <= 1'b0;
    end else begin
      if (acc_wr && (reg_off == REG_CTRL))     enable_o   <= apb_req_i.pwdata[0];
      if (acc_wr && (reg_off == REG_PRESCALE)) prescale_o <= apb_req_i.pwdata[`TIMER_PRESCALE_W-1:0];
      if (acc_wr && (reg_off == REG_COMPARE))  compare_o  <= apb_req_i.pwdata;
      if (match_i) begin
        status_q <= 1'b1; // A new match beats a clear
      end else if (acc_wr && (reg_off == REG_STATUS) && apb_req_i.pwdata[0]) begin
        status_q <= 1'b0; // Write 1 to clear
      end
    end
  end

  always_comb begin : read_mux
    apb_resp_o.pready  = 1'b1;
    apb_resp_o.pslverr = 1'b0;
    case (reg_off)
      REG_CTRL:     apb_resp_o.prdata = periph_data_t'(enable_o);
      REG_PRESCALE: apb_resp_o.prdata = periph_data_t'(prescale_o);
      REG_COUNT:    apb_resp_o.prdata = count_i; // Live count
      REG_COMPARE:  apb_resp_o.prdata = compare_o;
      REG_STATUS:   apb_resp_o.prdata = periph_data_t'(status_q);
      default:      apb_resp_o.prdata = '0;
    endcase
  end

endmodule

/* plic/irq_ctrl.sv */
// Level interrupt controller with a single target. Holds per-source
// priorities, an enable mask, a threshold, pending and in-service bits.
// Reading offset 0x18 claims the best source, writing an id there completes it.

`timescale 1ns/1ps

`include "periph_macros.svh"

module irq_ctrl
  import periph_bus_pkg::*;
  import periph_irq_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  apb_req_t  apb_req_i,
  output apb_resp_t apb_resp_o,
  input  irq_src_t  irq_src_i,
  output logic      irq_o
);

  // Word offsets, 0 to 3 are the priorities
  localparam logic [2:0] REG_ENABLE    = 3'd4;
  localparam logic [2:0] REG_THRESHOLD = 3'd5;
  localparam logic [2:0] REG_CLAIM     = 3'd6;
  localparam logic [2:0] REG_PENDING   = 3'd7;

  irq_prio_t  prio_q [`NUM_IRQ_SRC];
  irq_src_t   enable_q;
  irq_prio_t  threshold_q;
  irq_src_t   pending_q;
  irq_src_t   in_service_q;

  irq_id_t    best_id;
  irq_prio_t  best_prio;
  irq_src_t   claim_mask;
  irq_src_t   complete_mask;
  logic [2:0] reg_off;
  logic       acc_wr;
  logic       acc_rd;

  assign reg_off = apb_req_i.paddr[4:2];
  assign acc_wr  = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
  assign acc_rd  = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite;

  // ----------------------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------------------
  always_comb begin : arbiter
    best_id   = '0;
    best_prio = '0; // Priority 0 never wins
    for (int i = 0; i < `NUM_IRQ_SRC; i++) begin
      // Strict compare keeps the lowest id on a tie
      if (pending_q[i] && enable_q[i] && (prio_q[i] > best_prio)) begin
        best_id   = irq_id_t'(i + 1);
        best_prio = prio_q[i];
      end
    end
  end

  assign irq_o = (best_id != '0) && (best_prio > threshold_q);

  always_comb begin : claim_complete
    for (int i = 0; i < `NUM_IRQ_SRC; i++) begin
      claim_mask[i]    = acc_rd && (reg_off == REG_CLAIM) &&
                         (best_id == irq_id_t'(i + 1));
      complete_mask[i] = acc_wr && (reg_off == REG_CLAIM) &&
                         (apb_req_i.pwdata == periph_data_t'(i + 1));
    end
  end

  // ----------------------------------------------------------------------
  // Registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `NUM_IRQ_SRC; i++) begin
        prio_q[i] <= '0;
      end
      enable_q     <= '0;
      threshold_q  <= '0;
      pending_q    <= '0;
      in_service_q <= '0;
    end else begin
      // Claim wins over a source still high at the same edge
      pending_q    <= (pending_q | (irq_src_i & ~in_service_q)) & ~claim_mask;
      in_service_q <= (in_service_q | claim_mask) & ~complete_mask;
      if (acc_wr) begin
        if (!reg_off[2]) begin
          prio_q[reg_off[1:0]] <= apb_req_i.pwdata[`IRQ_PRIO_W-1:0];
        end else if (reg_off == REG_ENABLE) begin
          enable_q <= apb_req_i.pwdata[`NUM_IRQ_SRC-1:0];
        end else if (reg_off == REG_THRESHOLD) begin
          threshold_q <= apb_req_i.pwdata[`IRQ_PRIO_W-1:0];
        end
      end
    end
  end

  // Read data, zero wait states
  always_comb begin : read_mux
    apb_resp_o.pready  = 1'b1;
    apb_resp_o.pslverr = 1'b0;
    apb_resp_o.prdata  = '0;
    if (!reg_off[2]) begin
      apb_resp_o.prdata = periph_data_t'(prio_q[reg_off[1:0]]);
    end else begin
      case (reg_off)
        REG_ENABLE:    apb_resp_o.prdata = periph_data_t'(enable_q);
        REG_THRESHOLD: apb_resp_o.prdata = periph_data_t'(threshold_q);
        REG_CLAIM:     apb_resp_o.prdata = periph_data_t'(best_id);
        REG_PENDING:   apb_resp_o.prdata = periph_data_t'(pending_q);
        default:       apb_resp_o.prdata = '0;
      endcase
    end
  end

endmodule

/* source/apb_decoder.sv */
// APB address decoder. Forwards each access to the slave of its slot and
// answers unmapped slots with an error. Slot 0 offset 0x3C is served here
// and returns the number of error responses given so far.

`timescale 1ns/1ps

`include "periph_macros.svh"

module apb_decoder
  import periph_bus_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  apb_req_t                          apb_req_i,
  output apb_resp_t                         apb_resp_o,
  output apb_req_t  [`NUM_SLAVES-1:0]       slv_req_o,
  input  apb_resp_t [`NUM_SLAVES-1:0]       slv_resp_i
);

  localparam logic [`PERIPH_SLOT_LSB-3:0] ERR_CNT_WORD = 'h0F; // Byte offset 0x3C

  periph_slot_t slot;
  logic         mapped;
  logic         cnt_hit;
  logic         access;
  periph_data_t err_cnt_q;

  assign slot    = apb_req_i.paddr[`PERIPH_SLOT_LSB +: `PERIPH_SLOT_W];
  assign mapped  = slot < periph_slot_t'(`NUM_SLAVES);
  assign cnt_hit = (slot == periph_slot_t'(`IRQ_CTRL_SLOT)) &&
                   (apb_req_i.paddr[`PERIPH_SLOT_LSB-1:2] == ERR_CNT_WORD);
  assign access  = apb_req_i.psel & apb_req_i.penable;

  // ----------------------------------------------------------------------
  // Request fan-out and response select
  // ----------------------------------------------------------------------
  always_comb begin : route
    for (int i = 0; i < `NUM_SLAVES; i++) begin
      slv_req_o[i]      = apb_req_i;
      slv_req_o[i].psel = apb_req_i.psel && !cnt_hit &&
                          (slot == periph_slot_t'(i)); // One-hot select
    end

    // Unmapped slot by default
    apb_resp_o.pready  = 1'b1;
    apb_resp_o.prdata  = '0;
    apb_resp_o.pslverr = 1'b1;

    if (cnt_hit) begin
      apb_resp_o.prdata  = err_cnt_q; // Read-only, writes are ignored
      apb_resp_o.pslverr = 1'b0;
    end else begin
      for (int i = 0; i < `NUM_SLAVES; i++) begin
        if (slot == periph_slot_t'(i)) begin
          apb_resp_o = slv_resp_i[i];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Error response counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_cnt_q <= '0;
    end else if (access && !mapped) begin
      err_cnt_q <= err_cnt_q + 1'b1; // Zero wait states, one per access
    end
  end

endmodule

/* common/periph_irq_pkg.sv */
// Types of the interrupt controller: source vector, priority and claim id.
// Import where interrupt sources are formed or arbitrated.

`include "periph_macros.svh"

package periph_irq_pkg;

  // Bit n is source id n+1
  typedef logic [`NUM_IRQ_SRC-1:0] irq_src_t;

  // Also used for the threshold
  typedef logic [`IRQ_PRIO_W-1:0] irq_prio_t;

  // 0 means no interrupt, 1 to 4 name a source
  typedef logic [2:0] irq_id_t;

endpackage

/* common/periph_bus_pkg.sv */
// APB request and response structs and the address and data types.
// Import into any module that sits on the subsystem APB port.

`include "periph_macros.svh"

package periph_bus_pkg;

  typedef logic [`PERIPH_ADDR_W-1:0] periph_addr_t;
  typedef logic [`PERIPH_DATA_W-1:0] periph_data_t;
  typedef logic [`PERIPH_SLOT_W-1:0] periph_slot_t;

  // Master to slave, 71 bits
  typedef struct packed {
    periph_addr_t paddr;
    logic         psel;    // Held through setup and access
    logic         penable; // High in the access phase only
    logic         pwrite;
    periph_data_t pwdata;
    logic [3:0]   pstrb;
  } apb_req_t;

  // Slave to master, 34 bits
  typedef struct packed {
    logic         pready;  // Completes the access phase
    periph_data_t prdata;
    logic         pslverr;
  } apb_resp_t;

endpackage

/* common/periph_macros.svh */
// Address map, bus widths and interrupt counts of the peripheral subsystem.
// Include this header wherever a width or a slot number is needed.

`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// APB bus
`define PERIPH_ADDR_W    32
`define PERIPH_DATA_W    32
`define PERIPH_SLOT_LSB  12 // Slot field is paddr[15:12]
`define PERIPH_SLOT_W    4

// Slot map
`define IRQ_CTRL_SLOT    0
`define TIMER_SLOT       1
`define NUM_SLAVES       2

// Interrupts and timer
`define NUM_IRQ_SRC      4 // Timer plus three external lines
`define IRQ_PRIO_W       3
`define TIMER_PRESCALE_W 8

`endif
